// ==== design/fdc_pkg.sv ====
// Floppy track loader shared definitions
// Widths, disk geometry, bus structs and the loader FSM encoding
`default_nettype none

package fdc_pkg;

	// ==============================
	// Geometry and timing
	// ==============================

	// Drives sharing the SD port
	localparam int NUM_DRIVES = 2;
	// SD blocks that make up one track
	localparam int TRACK_BLOCKS = 13;
	// Bytes per SD block
	localparam int BLOCK_BYTES = 512;
	// Track buffer size, 13 x 512
	localparam int TRACK_BYTES = TRACK_BLOCKS * BLOCK_BYTES;
	// Clean cycles before system reset releases
	localparam int RESET_HOLD = 16;

	// ==============================
	// Plain vector types
	// ==============================

	typedef logic [7:0]  byte_t;
	typedef logic [5:0]  track_t;
	typedef logic [31:0] lba_t;
	typedef logic [3:0]  blk_idx_t;
	typedef logic [8:0]  sd_addr_t;
	typedef logic [12:0] buf_addr_t;
	typedef logic [0:0]  drive_id_t;
	// Reset hold counter
	typedef logic [$clog2(RESET_HOLD)-1:0] hold_cnt_t;

	// ==============================
	// Bus structs
	// ==============================

	// Disk controller request side
	typedef struct packed {
		track_t    track;
		buf_addr_t rd_addr;
	} drive_req_t;

	// Disk controller response side
	typedef struct packed {
		byte_t rd_data;
		logic  busy;
		logic  ready;
	} drive_rsp_t;

	// One SD data beat
	typedef struct packed {
		sd_addr_t offset;
		byte_t    data;
		logic     wr;
	} sd_beat_t;

	// Loader FSM
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		XFER,
		WAIT_END
	} loader_state_t;

endpackage

`default_nettype wire

// ==== design/track_buffer.sv ====
// Track buffer
// One track of bytes, one write port, registered read port
`default_nettype none

module track_buffer (
	input  wire logic              clk_sys,
	input  wire logic              wr_i,
	input  wire fdc_pkg::buf_addr_t wr_addr_i,
	input  wire fdc_pkg::byte_t     wr_data_i,
	input  wire fdc_pkg::buf_addr_t rd_addr_i,
	output fdc_pkg::byte_t          rd_data_o
);

	import fdc_pkg::*;

	// Track storage, maps to block RAM
	byte_t mem [TRACK_BYTES];

	// Loader side write port
	always_ff @(posedge clk_sys) begin
		if (wr_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// Controller side read
	// Data one cycle after address
	always_ff @(posedge clk_sys) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

// ==== design/track_loader.sv ====
// Per-drive track loader
// Tracks mount state and wanted track, fetches 13 SD blocks into the track buffer
`default_nettype none

module track_loader (
	input  wire logic               clk_sys,
	input  wire logic               rst_n_i,
	input  wire logic               mount_i,
	input  wire logic [63:0]        img_size_i,
	input  wire fdc_pkg::drive_req_t drv_req_i,
	output fdc_pkg::drive_rsp_t      drv_rsp_o,
	output logic                     blk_valid_o,
	output fdc_pkg::lba_t            blk_lba_o,
	input  wire logic               blk_ready_i,
	input  wire fdc_pkg::sd_beat_t   beat_i,
	input  wire logic               blk_done_i
);

	import fdc_pkg::*;

	loader_state_t state_q;
	logic          mounted_q;
	logic          reload_q;
	logic          busy_q;
	track_t        track_q;
	track_t        cur_track_q;
	blk_idx_t      blk_idx_q;

	logic      size_nz;
	logic      zero_mount;
	logic      trig;
	logic      blk_end;
	logic      last_blk;
	logic      wr_en;
	buf_addr_t wr_addr;
	byte_t     rd_data;

	// ==============================
	// Load triggers
	// ==============================

	assign size_nz    = img_size_i != 64'd0;
	assign zero_mount = mount_i && !size_nz;
	// New image, or controller stepped to another track
	assign trig = !zero_mount &&
		((mount_i && size_nz) || (mounted_q && (drv_req_i.track != track_q)));

	// Block finished on the SD side
	assign blk_end  = blk_done_i && ((state_q == XFER) || (state_q == WAIT_END));
	assign last_blk = blk_idx_q == blk_idx_t'(TRACK_BLOCKS - 1);

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mounted_q <= 1'b0;
			track_q   <= '0;
			reload_q  <= 1'b0;
			busy_q    <= 1'b0;
		end else begin
			if (mount_i) begin
				mounted_q <= size_nz;
			end
			// Remember the track the buffer is meant to hold
			if (trig) begin
				track_q <= drv_req_i.track;
			end
			// Pending restart, consumed at IDLE or a block boundary
			if (zero_mount) begin
				reload_q <= 1'b0;
			end else if (trig) begin
				reload_q <= 1'b1;
			end else if (reload_q && ((state_q == IDLE) || blk_end)) begin
				reload_q <= 1'b0;
			end
			// busy spans the whole track load
			if (trig) begin
				busy_q <= 1'b1;
			end else if ((blk_end && !reload_q && (last_blk || !mounted_q)) ||
				(state_q == IDLE && zero_mount)) begin
				busy_q <= 1'b0;
			end
		end
	end

	// ==============================
	// Block fetch FSM
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= IDLE;
			cur_track_q <= '0;
			blk_idx_q   <= '0;
		end else if (blk_end) begin
			if (reload_q) begin
				// Track changed mid-load, start over at block 0
				cur_track_q <= track_q;
				blk_idx_q   <= '0;
				state_q     <= REQ;
			end else if (last_blk || !mounted_q) begin
				state_q <= IDLE;
			end else begin
				blk_idx_q <= blk_idx_q + 1'b1;
				state_q   <= REQ;
			end
		end else begin
			case (state_q)
				IDLE: begin
					if (reload_q) begin
						cur_track_q <= track_q;
						blk_idx_q   <= '0;
						state_q     <= REQ;
					end
				end
				// Hold request until the arbiter takes it
				REQ: begin
					if (blk_ready_i) begin
						state_q <= XFER;
					end
				end
				// Last beat seen, wait for ack to drop
				XFER: begin
					if (beat_i.wr && (beat_i.offset == sd_addr_t'(BLOCK_BYTES - 1))) begin
						state_q <= WAIT_END;
					end
				end
				WAIT_END: begin
					state_q <= WAIT_END;
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	assign blk_valid_o = state_q == REQ;
	// Track times blocks per track plus block index
	assign blk_lba_o = lba_t'(cur_track_q) * lba_t'(TRACK_BLOCKS) + lba_t'(blk_idx_q);

	// Beats land at block base plus offset
	assign wr_en   = beat_i.wr && (state_q == XFER);
	assign wr_addr = buf_addr_t'(blk_idx_q) * buf_addr_t'(BLOCK_BYTES) +
		buf_addr_t'(beat_i.offset);

	track_buffer i_track_buffer (
		.clk_sys   (clk_sys),
		.wr_i      (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (beat_i.data),
		.rd_addr_i (drv_req_i.rd_addr),
		.rd_data_o (rd_data)
	);

	assign drv_rsp_o.rd_data = rd_data;
	assign drv_rsp_o.busy    = busy_q;
	assign drv_rsp_o.ready   = mounted_q;

endmodule

`default_nettype wire

// ==== design/sd_arbiter.sv ====
// SD block port arbiter
// Two-way round robin, owner keeps the port for a whole block
`default_nettype none

module sd_arbiter (
	input  wire logic                          clk_sys,
	input  wire logic                          rst_n_i,
	input  wire logic [fdc_pkg::NUM_DRIVES-1:0] blk_valid_i,
	input  wire fdc_pkg::lba_t                 blk_lba_i [fdc_pkg::NUM_DRIVES],
	output logic [fdc_pkg::NUM_DRIVES-1:0]      blk_ready_o,
	output fdc_pkg::sd_beat_t                   beat_o [fdc_pkg::NUM_DRIVES],
	output logic [fdc_pkg::NUM_DRIVES-1:0]      blk_done_o,
	output logic                                sd_rd_o,
	output fdc_pkg::lba_t                       sd_lba_o,
	output fdc_pkg::drive_id_t                  sd_drive_o,
	input  wire logic                          sd_ack_i,
	input  wire fdc_pkg::sd_beat_t             sd_beat_i
);

	import fdc_pkg::*;

	logic                  own_q;
	logic                  rd_q;
	logic                  ack_q;
	drive_id_t             owner_q;
	lba_t                  lba_q;
	logic [NUM_DRIVES-1:0] ready_q;

	drive_id_t win;
	logic      grant;
	logic      ack_fall;

	// Winner pick, owner_q doubles as last winner
	always_comb begin
		case (blk_valid_i)
			2'b01:   win = drive_id_t'(0);
			2'b10:   win = drive_id_t'(1);
			2'b11:   win = ~owner_q;
			default: win = owner_q;
		endcase
	end

	assign grant    = !own_q && (|blk_valid_i);
	// End of block is the falling edge of ack
	assign ack_fall = own_q && ack_q && !sd_ack_i;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			own_q   <= 1'b0;
			rd_q    <= 1'b0;
			ack_q   <= 1'b0;
			owner_q <= '0;
			lba_q   <= '0;
			ready_q <= '0;
		end else begin
			ack_q   <= sd_ack_i;
			ready_q <= '0;
			if (grant) begin
				own_q          <= 1'b1;
				owner_q        <= win;
				lba_q          <= blk_lba_i[win];
				ready_q[win]   <= 1'b1;
			end else if (ack_fall) begin
				own_q <= 1'b0;
			end
			// Request goes out right after the ready pulse
			if (|ready_q) begin
				rd_q <= 1'b1;
			end else if (sd_ack_i) begin
				rd_q <= 1'b0;
			end
		end
	end

	// Only the owner sees write strobes
	always_comb begin
		for (int i = 0; i < NUM_DRIVES; i++) begin
			beat_o[i]     = sd_beat_i;
			beat_o[i].wr  = sd_beat_i.wr && sd_ack_i && own_q && (owner_q == drive_id_t'(i));
			blk_done_o[i] = ack_fall && (owner_q == drive_id_t'(i));
		end
	end

	assign blk_ready_o = ready_q;
	assign sd_rd_o     = rd_q;
	assign sd_lba_o    = lba_q;
	assign sd_drive_o  = owner_q;

endmodule

`default_nettype wire

// ==== design/reset_stretch.sv ====
// System reset stretcher
// Merges pin reset and user request, holds reset for a fixed count after both clear
`default_nettype none

module reset_stretch (
	input  wire logic clk_sys,
	input  wire logic rst_n_i,
	input  wire logic reset_req_i,
	output logic      sys_rst_n_o
);

	import fdc_pkg::*;

	logic      req_q;
	logic      sys_rst_q;
	hold_cnt_t cnt_q;

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			req_q     <= 1'b1;
			sys_rst_q <= 1'b0;
			cnt_q     <= '0;
		end else begin
			// Synchronized user request
			req_q <= reset_req_i;
			if (req_q) begin
				sys_rst_q <= 1'b0;
				cnt_q     <= '0;
			end else if (!sys_rst_q) begin
				// One cycle already spent in the request flop
				if (cnt_q == hold_cnt_t'(RESET_HOLD - 2)) begin
					sys_rst_q <= 1'b1;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	assign sys_rst_n_o = sys_rst_q;

endmodule

`default_nettype wire

// ==== design/floppy_top.sv ====
// Floppy subsystem top
// Reset stretcher, two track loaders and the shared SD port arbiter
`default_nettype none

module floppy_top (
	input  wire logic                          clk_sys,
	input  wire logic                          rst_n_i,
	input  wire logic                          reset_req_i,
	input  wire logic [fdc_pkg::NUM_DRIVES-1:0] img_mounted_i,
	input  wire logic [63:0]                   img_size_i,
	input  wire fdc_pkg::drive_req_t           drv_req_i [fdc_pkg::NUM_DRIVES],
	output fdc_pkg::drive_rsp_t                 drv_rsp_o [fdc_pkg::NUM_DRIVES],
	output logic                                sd_rd_o,
	output fdc_pkg::lba_t                       sd_lba_o,
	output fdc_pkg::drive_id_t                  sd_drive_o,
	input  wire logic                          sd_ack_i,
	input  wire fdc_pkg::sd_beat_t             sd_beat_i
);

	import fdc_pkg::*;

	// ==============================
	// Internal nets
	// ==============================

	logic                  sys_rst_n;
	logic [NUM_DRIVES-1:0] blk_valid;
	logic [NUM_DRIVES-1:0] blk_ready;
	logic [NUM_DRIVES-1:0] blk_done;
	lba_t                  blk_lba [NUM_DRIVES];
	sd_beat_t              beat [NUM_DRIVES];

	// Stretched reset for everything below
	reset_stretch i_reset_stretch (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.reset_req_i (reset_req_i),
		.sys_rst_n_o (sys_rst_n)
	);

	// One loader and track buffer per drive
	for (genvar d = 0; d < NUM_DRIVES; d++) begin : g_drive
		track_loader i_track_loader (
			.clk_sys     (clk_sys),
			.rst_n_i     (sys_rst_n),
			.mount_i     (img_mounted_i[d]),
			.img_size_i  (img_size_i),
			.drv_req_i   (drv_req_i[d]),
			.drv_rsp_o   (drv_rsp_o[d]),
			.blk_valid_o (blk_valid[d]),
			.blk_lba_o   (blk_lba[d]),
			.blk_ready_i (blk_ready[d]),
			.beat_i      (beat[d]),
			.blk_done_i  (blk_done[d])
		);
	end

	// Shared SD block port
	sd_arbiter i_sd_arbiter (
		.clk_sys     (clk_sys),
		.rst_n_i     (sys_rst_n),
		.blk_valid_i (blk_valid),
		.blk_lba_i   (blk_lba),
		.blk_ready_o (blk_ready),
		.beat_o      (beat),
		.blk_done_o  (blk_done),
		.sd_rd_o     (sd_rd_o),
		.sd_lba_o    (sd_lba_o),
		.sd_drive_o  (sd_drive_o),
		.sd_ack_i    (sd_ack_i),
		.sd_beat_i   (sd_beat_i)
	);

endmodule

`default_nettype wire

// ==== test/floppy_assert.sv ====
// SD port protocol checks
// Request hold, address stability and beat strobes only under acknowledge
`default_nettype none

module floppy_assert (
	input wire logic               clk_sys,
	input wire logic               rst_n_i,
	input wire logic               sd_rd_o,
	input wire logic               sd_ack_i,
	input wire fdc_pkg::lba_t      sd_lba_o,
	input wire fdc_pkg::drive_id_t sd_drive_o,
	input wire fdc_pkg::sd_beat_t  sd_beat_i
);

	// Request held until acknowledge
	a_rd_hold: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(sd_rd_o && !sd_ack_i) |=> sd_rd_o)
		else $error("sd_rd_o dropped before sd_ack_i");

	// Address and drive stay put while requesting
	a_lba_stable: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(sd_rd_o && !sd_ack_i) |=> ($stable(sd_lba_o) && $stable(sd_drive_o)))
		else $error("sd_lba_o or sd_drive_o changed during request");

	// Beats only inside acknowledge
	a_beat_in_ack: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		!sd_ack_i |-> !sd_beat_i.wr)
		else $error("beat write strobe without sd_ack_i");

endmodule

bind floppy_top floppy_assert i_floppy_assert (
	.clk_sys    (clk_sys),
	.rst_n_i    (rst_n_i),
	.sd_rd_o    (sd_rd_o),
	.sd_ack_i   (sd_ack_i),
	.sd_lba_o   (sd_lba_o),
	.sd_drive_o (sd_drive_o),
	.sd_beat_i  (sd_beat_i)
);

`default_nettype wire

// ==== test/floppy_tb.sv ====
// Floppy subsystem testbench
// SD host model with random timing, reference image bytes, track readback checks
`default_nettype none

module floppy_tb;

	import fdc_pkg::*;

	// Loads, readbacks and worst block time bound the watchdog
	localparam int LOADS     = 10;
	localparam int READS     = 10;
	localparam int WORST_BLK = BLOCK_BYTES * 3 + 16;
	localparam longint LIMIT =
		(LOADS * TRACK_BLOCKS * WORST_BLK + READS * (TRACK_BYTES + 8) + 3000) * 20;

	logic                  clk_sys = 1'b0;
	logic                  rst_n_i;
	logic                  reset_req_i;
	logic [NUM_DRIVES-1:0] img_mounted_i;
	logic [63:0]           img_size_i;
	drive_req_t            drv_req [NUM_DRIVES];
	drive_rsp_t            drv_rsp [NUM_DRIVES];
	logic                  sd_rd_o;
	lba_t                  sd_lba_o;
	drive_id_t             sd_drive_o;
	logic                  sd_ack_i;
	sd_beat_t              sd_beat_i;

	logic [31:0] rng_state = 32'h708531ac;
	int          gen [NUM_DRIVES];
	int          req_cnt [NUM_DRIVES];
	drive_id_t   req_log [$];

	// Readback compare pipeline
	logic  rd_vld_a = 1'b0;
	logic  rd_vld_b = 1'b0;
	byte_t rd_exp_a;
	byte_t rd_exp_b;
	int    rd_drv_a;
	int    rd_drv_b;

	floppy_top i_floppy_top (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.reset_req_i   (reset_req_i),
		.img_mounted_i (img_mounted_i),
		.img_size_i    (img_size_i),
		.drv_req_i     (drv_req),
		.drv_rsp_o     (drv_rsp),
		.sd_rd_o       (sd_rd_o),
		.sd_lba_o      (sd_lba_o),
		.sd_drive_o    (sd_drive_o),
		.sd_ack_i      (sd_ack_i),
		.sd_beat_i     (sd_beat_i)
	);

	always #10 clk_sys = ~clk_sys;

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [31:0] xorshift();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Image byte for a drive, image generation, block and offset
	function automatic byte_t ref_byte(input int drv, input int g, input lba_t lba, input int off);
		logic [31:0] h;
		h = (lba * 32'h9e3779b1) ^ (off * 32'h000085eb) ^ (drv << 20) ^ (g * 32'h27d4eb2f);
		h = h ^ (h >> 13);
		return h[7:0] ^ h[15:8];
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	always @(posedge clk_sys) begin
		rd_vld_b <= rd_vld_a;
		rd_exp_b <= rd_exp_a;
		rd_drv_b <= rd_drv_a;
	end

	// Data is registered one cycle after the address
	always @(negedge clk_sys) begin
		if (rd_vld_b) begin
			check($sformatf("drv_rsp_o[%0d].rd_data", rd_drv_b), 32'(drv_rsp[rd_drv_b].rd_data),
				32'(rd_exp_b));
		end
	end

	task automatic mount(input logic [1:0] mask, input logic [63:0] size, input int t0,
		input int t1);
		@(posedge clk_sys);
		img_mounted_i <= mask;
		img_size_i    <= size;
		if (mask[0]) drv_req[0].track <= track_t'(t0);
		if (mask[1]) drv_req[1].track <= track_t'(t1);
		@(posedge clk_sys);
		img_mounted_i <= '0;
	endtask

	task automatic wait_load(input int d);
		repeat (2) @(posedge clk_sys);
		while (drv_rsp[d].busy) @(posedge clk_sys);
	endtask

	// Read the whole buffer against the image bytes of that track
	task automatic read_track(input int d, input int t);
		lba_t lba;
		check("drv_rsp_o.busy", 32'(drv_rsp[d].busy), 0);
		check("drv_rsp_o.ready", 32'(drv_rsp[d].ready), 1);
		for (int a = 0; a < TRACK_BYTES; a++) begin
			lba = lba_t'(t * TRACK_BLOCKS + a / BLOCK_BYTES);
			@(posedge clk_sys);
			drv_req[d].rd_addr <= buf_addr_t'(a);
			rd_exp_a <= ref_byte(d, gen[d], lba, a % BLOCK_BYTES);
			rd_drv_a <= d;
			rd_vld_a <= 1'b1;
		end
		@(posedge clk_sys);
		rd_vld_a <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// ==============================
	// SD host model
	// ==============================

	initial begin
		int gap;
		int drv;
		forever begin
			@(posedge clk_sys);
			if (sd_rd_o) begin
				drv = int'(sd_drive_o);
				req_log.push_back(sd_drive_o);
				req_cnt[drv]++;
				repeat (xorshift() % 8) @(posedge clk_sys);
				sd_ack_i <= 1'b1;
				for (int off = 0; off < BLOCK_BYTES; off++) begin
					gap = ((xorshift() & 7) == 0) ? int'(xorshift() % 3) : 0;
					// Idle cycles drop the strobe after the previous beat
					if (gap > 0) begin
						@(posedge clk_sys);
						sd_beat_i.wr <= 1'b0;
						repeat (gap - 1) @(posedge clk_sys);
					end
					@(posedge clk_sys);
					sd_beat_i.offset <= sd_addr_t'(off);
					sd_beat_i.data   <= ref_byte(drv, gen[drv], sd_lba_o, off);
					sd_beat_i.wr     <= 1'b1;
				end
				@(posedge clk_sys);
				sd_beat_i.wr <= 1'b0;
				@(posedge clk_sys);
				sd_ack_i <= 1'b0;
			end
		end
	end

	initial begin
		#(LIMIT);
		$display("Watchdog expired, a track load or readback never finished");
		$display("TESTS FAILED");
		$fatal(1);
	end

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		rst_n_i       = 1'b0;
		reset_req_i   = 1'b0;
		img_mounted_i = '0;
		img_size_i    = '0;
		sd_ack_i      = 1'b0;
		sd_beat_i     = '0;
		drv_req[0]    = '0;
		drv_req[1]    = '0;
		gen[0]        = 1;
		gen[1]        = 1;
		req_cnt[0]    = 0;
		req_cnt[1]    = 0;
		repeat (4) @(posedge clk_sys);
		rst_n_i <= 1'b1;
		repeat (RESET_HOLD + 4) @(posedge clk_sys);

		// Single drive, track 5 covers lba 65..77
		mount(2'b01, 64'd174848, 5, 0);
		wait_load(0);
		read_track(0, 5);

		// Both drives at once, grants must alternate
		req_log.delete();
		gen[0] = 2;
		mount(2'b11, 64'd174848, 12, 20);
		wait_load(0);
		wait_load(1);
		check("sd request count", 32'(req_log.size()), 32'(2 * TRACK_BLOCKS));
		for (int i = 1; i < req_log.size(); i++) begin
			check("sd_drive_o alternation", 32'(req_log[i] != req_log[i-1]), 1);
		end
		read_track(0, 12);
		read_track(1, 20);

		// Remount on the same track reloads the new image
		gen[1] = 3;
		mount(2'b10, 64'd174848, 0, 20);
		@(posedge clk_sys);
		check("drv_rsp_o[1].busy", 32'(drv_rsp[1].busy), 1);
		wait_load(1);
		read_track(1, 20);

		// Empty image leaves drive 1 unusable
		mount(2'b10, 64'd0, 0, 20);
		req_cnt[1] = 0;
		@(posedge clk_sys);
		drv_req[1].track <= track_t'(21);
		repeat (60) @(posedge clk_sys);
		check("drv_rsp_o[1].ready", 32'(drv_rsp[1].ready), 0);
		check("drive 1 sd requests", 32'(req_cnt[1]), 0);

		// User reset request in the middle of a block
		@(posedge clk_sys);
		drv_req[0].track <= track_t'(3);
		while (!sd_ack_i) @(posedge clk_sys);
		check("drv_rsp_o[0].busy", 32'(drv_rsp[0].busy), 1);
		reset_req_i <= 1'b1;
		repeat (4) @(posedge clk_sys);
		check("drv_rsp_o[0].ready", 32'(drv_rsp[0].ready), 0);
		check("drv_rsp_o[0].busy", 32'(drv_rsp[0].busy), 0);
		// Mounts inside the hold window, first and last cycle, are ignored
		img_size_i  <= 64'd174848;
		reset_req_i <= 1'b0;
		for (int i = 0; i < RESET_HOLD; i++) begin
			@(posedge clk_sys);
			check("sd_rd_o", 32'(sd_rd_o), 0);
			img_mounted_i <= ((i == 0) || (i == RESET_HOLD - 2)) ? 2'b01 : 2'b00;
		end
		repeat (4) @(posedge clk_sys);
		check("drv_rsp_o[0].ready", 32'(drv_rsp[0].ready), 0);
		check("drv_rsp_o[0].busy", 32'(drv_rsp[0].busy), 0);
		// Interrupted block drains on the host side
		while (sd_ack_i) @(posedge clk_sys);
		gen[0] = 4;
		mount(2'b01, 64'd174848, 7, 0);
		wait_load(0);
		read_track(0, 7);

		// Several tracks under random host timing
		gen[1] = 5;
		mount(2'b10, 64'd174848, 0, 30);
		wait_load(1);
		read_track(1, 30);
		for (int t = 1; t <= 3; t++) begin
			@(posedge clk_sys);
			drv_req[0].track <= track_t'(t * 9);
			wait_load(0);
			read_track(0, t * 9);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
design/fdc_pkg.sv
design/track_buffer.sv
design/track_loader.sv
design/sd_arbiter.sv
design/reset_stretch.sv
design/floppy_top.sv
test/floppy_assert.sv
test/floppy_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the floppy testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module floppy_tb \
	-o floppy_sim

output=$(./obj_dir/floppy_sim)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
	exit 0
else
	exit 1
fi
